//--- filelist.f
+incdir+dv
verilog/renamePkg.sv
verilog/mapTableRam.sv
verilog/initCounter.sv
verilog/initSequencer.sv
verilog/retirementMapTable.sv
verilog/freeRegList.sv
verilog/retireRename.sv
dv/retireRenameTb.sv

//--- run.sh
#!/bin/sh
# Build and run the retirement renamer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --assert --top-module retireRenameTb -f filelist.f \
        -Mdir "$BUILD_DIR" -o retireRenameSim; then
    echo "Build failed"
    exit 1
fi

if ! "./$BUILD_DIR/retireRenameSim" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

//--- dv/retireRenameTbTable.svh
/*
 * Stimulus table for the retirement renamer testbench.
 * Directed steps for draining the free list, single and paired commits.
 */

// Columns: rep, lane 0 {valid, logReg, phyReg}, lane 1 {valid, logReg, phyReg},
// read 0, read 1, allocReq, checkAlloc (compare allocPhyReg and freeEmpty)
typedef struct packed {
    logic [5:0] rep;
    commitLane_t lane0;
    commitLane_t lane1;
    logRegNum_t read0;
    logRegNum_t read1;
    logic allocReq;
    logic checkAlloc;
} step_t;

localparam commitLane_t IDLE_LANE = '{1'b0, 5'd0, 6'd0};

localparam int STEP_NUM = 11;

localparam step_t STEPS [STEP_NUM] = '{
    // Drain all 32 initial free registers in order
    '{6'd32, IDLE_LANE, IDLE_LANE, 5'd0, 5'd1, 1'b1, 1'b1},
    '{6'd1, IDLE_LANE, IDLE_LANE, 5'd0, 5'd0, 1'b0, 1'b1},
    // Single commit, old mapping still visible this cycle
    '{6'd1, '{1'b1, 5'd5, 6'd0}, IDLE_LANE, 5'd5, 5'd6, 1'b0, 1'b1},
    '{6'd1, IDLE_LANE, IDLE_LANE, 5'd5, 5'd5, 1'b0, 1'b1},
    // Both lanes to r9, lane 1 should win
    '{6'd1, '{1'b1, 5'd9, 6'd1}, '{1'b1, 5'd9, 6'd2}, 5'd9, 5'd9, 1'b0, 1'b1},
    '{6'd1, IDLE_LANE, IDLE_LANE, 5'd9, 5'd5, 1'b0, 1'b1},
    '{6'd1, IDLE_LANE, IDLE_LANE, 5'd9, 5'd10, 1'b1, 1'b1},
    // Different registers with a pop in the same cycle
    '{6'd1, '{1'b1, 5'd3, 6'd3}, '{1'b1, 5'd20, 6'd4}, 5'd3, 5'd20, 1'b1, 1'b1},
    '{6'd1, '{1'b1, 5'd3, 6'd5}, '{1'b1, 5'd7, 6'd6}, 5'd3, 5'd20, 1'b1, 1'b1},
    '{6'd3, IDLE_LANE, IDLE_LANE, 5'd3, 5'd7, 1'b1, 1'b1},
    '{6'd1, IDLE_LANE, IDLE_LANE, 5'd7, 5'd3, 1'b0, 1'b1}
};

//--- dv/retireRenameTb.sv
/*
 * Testbench for the retirement renamer.
 * Checks the post-reset sweep, recovery reads, free list order and
 * same-cycle commits against a map array and free queue model.
 */
module retireRenameTb;
    timeunit 1ns;
    timeprecision 1ps;
    import renamePkg::*;

    `include "retireRenameTbTable.svh"

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 4;
    localparam int SWEEP_CYCLES = LOG_REG_NUM + 1;
    localparam int READ_SWEEP_CYCLES = LOG_REG_NUM / READ_WIDTH;
    localparam int RANDOM_COUNT = 40;
    localparam int MARGIN_CYCLES = 20;

    logic clk = 1'b0;
    logic rstN;
    commitLane_t [COMMIT_WIDTH-1:0] commit;
    logRegNum_t [READ_WIDTH-1:0] readLogReg;
    logic allocReq;
    phyRegNum_t [READ_WIDTH-1:0] readPhyReg;
    phyRegNum_t allocPhyReg;
    logic freeEmpty;
    logic ready;

    // Reference model
    phyRegNum_t mapModel [LOG_REG_NUM];
    phyRegNum_t freeQ [$];

    int errorCount = 0;
    int checkCount = 0;
    int seed = 32'h5abb8edc;

    retireRename retireRename_inst (
        .clk        (clk),
        .rstN       (rstN),
        .commit     (commit),
        .readLogReg (readLogReg),
        .allocReq   (allocReq),
        .readPhyReg (readPhyReg),
        .allocPhyReg(allocPhyReg),
        .freeEmpty  (freeEmpty),
        .ready      (ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic checkValue(input string what, input int got, input int expected);
        checkCount++;
        if (got != expected) begin
            errorCount++;
            $display("mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    function automatic int tableCycles();
        int total;
        total = 0;
        for (int i = 0; i < STEP_NUM; i++) begin
            total += int'(STEPS[i].rep);
        end
        return total;
    endfunction

    // Old mappings in program order, pop first, then pushes lane by lane
    task automatic updateModel(input step_t s);
        phyRegNum_t old0;
        phyRegNum_t old1;
        old0 = mapModel[s.lane0.logReg];
        old1 = mapModel[s.lane1.logReg];
        if (s.lane0.valid && s.lane0.logReg == s.lane1.logReg) begin
            old1 = s.lane0.phyReg;
        end
        if (s.allocReq) begin
            void'(freeQ.pop_front());
        end
        if (s.lane0.valid) begin
            freeQ.push_back(old0);
            mapModel[s.lane0.logReg] = s.lane0.phyReg;
        end
        if (s.lane1.valid) begin
            freeQ.push_back(old1);
            mapModel[s.lane1.logReg] = s.lane1.phyReg;
        end
    endtask

    task automatic applyStep(input step_t s);
        @(posedge clk);
        commit[0] <= s.lane0;
        commit[1] <= s.lane1;
        readLogReg[0] <= s.read0;
        readLogReg[1] <= s.read1;
        allocReq <= s.allocReq;
        @(negedge clk);
        checkValue("readPhyReg[0]", int'(readPhyReg[0]), int'(mapModel[s.read0]));
        checkValue("readPhyReg[1]", int'(readPhyReg[1]), int'(mapModel[s.read1]));
        if (s.checkAlloc) begin
            checkValue("freeEmpty", int'(freeEmpty), int'(freeQ.size() == 0));
            if (freeQ.size() > 0) begin
                checkValue("allocPhyReg", int'(allocPhyReg), int'(freeQ[0]));
            end
        end
        updateModel(s);
    endtask

    // Pops only from a non-empty queue, pushes only while there is room
    function automatic step_t buildRandomStep();
        step_t s;
        logic [31:0] r0;
        logic [31:0] r1;
        int room;
        r0 = $random(seed);
        r1 = $random(seed);
        s = '0;
        s.rep = 6'd1;
        s.lane0 = r0[$bits(commitLane_t)-1:0];
        s.lane1 = r1[$bits(commitLane_t)-1:0];
        s.read0 = r0[20:16];
        s.read1 = r1[20:16];
        s.allocReq = (freeQ.size() > 0) && (r0[24] == 1'b1);
        s.checkAlloc = 1'b1;
        room = FREE_LIST_ENTRY_NUM - freeQ.size() + int'(s.allocReq);
        if (room < 1) begin
            s.lane0.valid = 1'b0;
        end
        if (room < 1 + int'(s.lane0.valid)) begin
            s.lane1.valid = 1'b0;
        end
        return s;
    endfunction

    initial begin
        step_t s;
        rstN = 1'b0;
        commit = '0;
        readLogReg = '0;
        allocReq = 1'b0;
        for (int r = 0; r < LOG_REG_NUM; r++) begin
            mapModel[r] = phyRegNum_t'(r + FREE_LIST_ENTRY_NUM);
        end
        for (int i = 0; i < FREE_LIST_ENTRY_NUM; i++) begin
            freeQ.push_back(phyRegNum_t'(i));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;

        // ready must come up on the 33rd edge after release
        for (int k = 1; k <= SWEEP_CYCLES; k++) begin
            @(posedge clk);
            @(negedge clk);
            checkValue("ready", int'(ready), int'(k == SWEEP_CYCLES));
            checkValue("freeEmpty", int'(freeEmpty), int'(k != SWEEP_CYCLES));
        end

        for (int r = 0; r < READ_SWEEP_CYCLES; r++) begin
            s = '0;
            s.rep = 6'd1;
            s.read0 = logRegNum_t'(2 * r);
            s.read1 = logRegNum_t'(2 * r + 1);
            s.checkAlloc = 1'b1;
            applyStep(s);
        end
        for (int i = 0; i < STEP_NUM; i++) begin
            for (int n = 0; n < int'(STEPS[i].rep); n++) begin
                applyStep(STEPS[i]);
            end
        end
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            applyStep(buildRandomStep());
        end

        // Last step lands, inputs go idle
        @(posedge clk);
        commit <= '0;
        allocReq <= 1'b0;
        @(negedge clk);

        $display("Errors: %0d in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = RESET_CYCLES + SWEEP_CYCLES + READ_SWEEP_CYCLES;
        limit = limit + tableCycles() + RANDOM_COUNT + MARGIN_CYCLES;
        #(limit * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule : retireRenameTb

//--- verilog/retireRename.sv
/*
 * Retirement renamer top.
 * Ties the init sequencer and sweep counter to the retirement map
 * table and the free register list.
 */
module retireRename (
    input  logic                                                 clk,
    input  logic                                                 rstN,
    input  renamePkg::commitLane_t [renamePkg::COMMIT_WIDTH-1:0] commit,
    input  renamePkg::logRegNum_t [renamePkg::READ_WIDTH-1:0]    readLogReg,
    input  logic                                                 allocReq,
    output renamePkg::phyRegNum_t [renamePkg::READ_WIDTH-1:0]    readPhyReg,
    output renamePkg::phyRegNum_t                                allocPhyReg,
    output logic                                                 freeEmpty,
    output logic                                                 ready
);
    import renamePkg::*;

    logic sweepStart;
    logic sweepActive;
    logic sweepLast;
    sweepIdx_t sweepIdx;

    // Replaced mappings on their way to the free list
    logic [COMMIT_WIDTH-1:0] freedValid;
    phyRegNum_t [COMMIT_WIDTH-1:0] freedPhyReg;

    initSequencer initSequencer_inst (
        .clk        (clk),
        .rstN       (rstN),
        .sweepLast  (sweepLast),
        .sweepStart (sweepStart),
        .sweepActive(sweepActive),
        .ready      (ready)
    );

    initCounter initCounter_inst (
        .clk        (clk),
        .rstN       (rstN),
        .sweepStart (sweepStart),
        .sweepActive(sweepActive),
        .sweepIdx   (sweepIdx),
        .sweepLast  (sweepLast)
    );

    retirementMapTable retirementMapTable_inst (
        .clk        (clk),
        .rstN       (rstN),
        .sweepActive(sweepActive),
        .sweepIdx   (sweepIdx),
        .commit     (commit),
        .readLogReg (readLogReg),
        .readPhyReg (readPhyReg),
        .freedValid (freedValid),
        .freedPhyReg(freedPhyReg)
    );

    freeRegList freeRegList_inst (
        .clk        (clk),
        .rstN       (rstN),
        .sweepActive(sweepActive),
        .sweepIdx   (sweepIdx),
        .sweepLast  (sweepLast),
        .freedValid (freedValid),
        .freedPhyReg(freedPhyReg),
        .allocReq   (allocReq),
        .allocPhyReg(allocPhyReg),
        .freeEmpty  (freeEmpty)
    );

endmodule : retireRename

//--- verilog/freeRegList.sv
/*
 * Free physical register list.
 * Circular FIFO with one push per commit lane and a single pop.
 * The post-reset sweep loads slot i with register i and marks it full.
 */
module freeRegList (
    input  logic                                                clk,
    input  logic                                                rstN,
    input  logic                                                sweepActive,
    input  renamePkg::sweepIdx_t                                sweepIdx,
    input  logic                                                sweepLast,
    input  logic [renamePkg::COMMIT_WIDTH-1:0]                  freedValid,
    input  renamePkg::phyRegNum_t [renamePkg::COMMIT_WIDTH-1:0] freedPhyReg,
    input  logic                                                allocReq,
    output renamePkg::phyRegNum_t                               allocPhyReg,
    output logic                                                freeEmpty
);
    import renamePkg::*;

    // Capacity is a power of two so pointers wrap on their own
    localparam int PTR_WIDTH = $clog2(FREE_LIST_ENTRY_NUM);
    localparam int COUNT_WIDTH = $clog2(FREE_LIST_ENTRY_NUM + 1);

    typedef logic [PTR_WIDTH-1:0] freePtr_t;
    typedef logic [COUNT_WIDTH-1:0] freeCount_t;

    phyRegNum_t slot [FREE_LIST_ENTRY_NUM];

    freePtr_t head;
    freePtr_t tail;
    freeCount_t count;

    freePtr_t [COMMIT_WIDTH-1:0] pushPtr;
    freeCount_t pushNum;

    // Each valid lane takes the next slot after the older ones
    always_comb begin
        pushNum = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            pushPtr[i] = tail + freePtr_t'(pushNum);
            if (freedValid[i]) begin
                pushNum = pushNum + freeCount_t'(1);
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (sweepActive) begin
            slot[sweepIdx] <= phyRegNum_t'(sweepIdx);
        end else begin
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (freedValid[i]) begin
                    slot[pushPtr[i]] <= freedPhyReg[i];
                end
            end
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rstN) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else if (sweepActive) begin
            if (sweepLast) begin
                tail <= '0;
                count <= freeCount_t'(FREE_LIST_ENTRY_NUM);
            end
        end else begin
            tail <= tail + freePtr_t'(pushNum);
            head <= head + freePtr_t'(allocReq);
            count <= count + pushNum - freeCount_t'(allocReq);
        end
    end

    assign allocPhyReg = slot[head];
    assign freeEmpty = (count == '0);

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
        allocReq |-> !freeEmpty)
        else $error("freeRegList: allocation from an empty free list");

    // Registers in use are conserved by the map table
    countInRange: assert property (@(posedge clk) disable iff (!rstN)
        count <= freeCount_t'(FREE_LIST_ENTRY_NUM))
        else $error("freeRegList: count above capacity");

endmodule : freeRegList

//--- verilog/retirementMapTable.sv
/*
 * Retirement map table.
 * Holds the committed logical to physical mapping, resolves same-cycle
 * commits to one register in favour of the younger lane and reports
 * the mapping each lane replaces. Filled by the post-reset sweep.
 */
module retirementMapTable (
    input  logic                                                 clk,
    input  logic                                                 rstN,
    input  logic                                                 sweepActive,
    input  renamePkg::sweepIdx_t                                 sweepIdx,
    input  renamePkg::commitLane_t [renamePkg::COMMIT_WIDTH-1:0] commit,
    input  renamePkg::logRegNum_t [renamePkg::READ_WIDTH-1:0]    readLogReg,
    output renamePkg::phyRegNum_t [renamePkg::READ_WIDTH-1:0]    readPhyReg,
    output logic [renamePkg::COMMIT_WIDTH-1:0]                   freedValid,
    output renamePkg::phyRegNum_t [renamePkg::COMMIT_WIDTH-1:0]  freedPhyReg
);
    import renamePkg::*;

    logic [COMMIT_WIDTH-1:0] ramWe;
    logRegNum_t [COMMIT_WIDTH-1:0] ramWa;
    phyRegNum_t [COMMIT_WIDTH-1:0] ramWv;
    logRegNum_t [MAP_READ_NUM-1:0] ramRa;
    phyRegNum_t [MAP_READ_NUM-1:0] ramRv;

    logic [COMMIT_WIDTH-1:0] commitValid;
    phyRegNum_t sweepPhyReg;

    mapTableRam mapTableRam_inst (
        .clk(clk),
        .we (ramWe),
        .wa (ramWa),
        .wv (ramWv),
        .ra (ramRa),
        .rv (ramRv)
    );

    // Free list holds 0..31, so the initial mapping starts above it
    assign sweepPhyReg = phyRegNum_t'(sweepIdx) + phyRegNum_t'(FREE_LIST_ENTRY_NUM);

    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commitValid[i] = commit[i].valid;
        end
    end

    // Write ports
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (sweepActive) begin
                // Only port 0 fills the table
                ramWe[i] = (i == 0);
                ramWa[i] = logRegNum_t'(sweepIdx);
                ramWv[i] = sweepPhyReg;
            end else begin
                ramWe[i] = commit[i].valid;
                ramWa[i] = commit[i].logReg;
                ramWv[i] = commit[i].phyReg;
            end
        end

        // Younger lane wins on a shared logical register
        for (int i = 1; i < COMMIT_WIDTH; i++) begin
            for (int j = 0; j < i; j++) begin
                if (ramWe[i] && ramWa[i] == ramWa[j]) begin
                    ramWe[j] = 1'b0;
                end
            end
        end
    end

    // Recovery reads then per-lane lookups
    always_comb begin
        for (int k = 0; k < READ_WIDTH; k++) begin
            ramRa[k] = readLogReg[k];
            readPhyReg[k] = ramRv[k];
        end
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            ramRa[READ_WIDTH + i] = commit[i].logReg;
        end
    end

    // Old mapping in program order
    // an older lane to the same register supersedes the table value
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            freedPhyReg[i] = ramRv[READ_WIDTH + i];
            for (int j = 0; j < i; j++) begin
                if (commit[j].valid && commit[j].logReg == commit[i].logReg) begin
                    freedPhyReg[i] = commit[j].phyReg;
                end
            end
        end
    end

    assign freedValid = commitValid;

    noCommitInSweep: assert property (@(posedge clk) disable iff (!rstN)
        sweepActive |-> commitValid == '0)
        else $error("retirementMapTable: commit during init sweep");

endmodule : retirementMapTable

//--- verilog/initSequencer.sv
/*
 * Post-reset init sequencer.
 * Starts the sweep counter, holds the sweep active until the last
 * index and then raises ready until the next reset.
 */
module initSequencer (
    input  logic clk,
    input  logic rstN,
    input  logic sweepLast,
    output logic sweepStart,
    output logic sweepActive,
    output logic ready
);
    import renamePkg::*;

    initState_t state;
    initState_t nextState;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= INIT_START;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            INIT_START: nextState = INIT_SWEEP;
            INIT_SWEEP: begin
                if (sweepLast) begin
                    nextState = READY;
                end
            end
            READY: nextState = READY;
            default: nextState = INIT_START;
        endcase
    end

    assign sweepStart = (state == INIT_START);
    assign sweepActive = (state == INIT_SWEEP);
    assign ready = (state == READY);

    // Ready only drops through reset
    readySticky: assert property (@(posedge clk) disable iff (!rstN)
        ready |=> ready)
        else $error("initSequencer: ready fell without reset");

endmodule : initSequencer

//--- verilog/initCounter.sv
/*
 * Sweep index counter.
 * Walks every logical register index once and flags the last one.
 */
module initCounter (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 sweepStart,
    input  logic                 sweepActive,
    output renamePkg::sweepIdx_t sweepIdx,
    output logic                 sweepLast
);
    import renamePkg::*;

    always_ff @(posedge clk) begin
        if (!rstN || sweepStart) begin
            sweepIdx <= '0;
        end else if (sweepActive) begin
            sweepIdx <= sweepIdx + sweepIdx_t'(1);
        end
    end

    assign sweepLast = sweepActive && (sweepIdx == sweepIdx_t'(LOG_REG_NUM - 1));

endmodule : initCounter

//--- verilog/mapTableRam.sv
/*
 * Map table storage.
 * Register-based RAM with one write port per commit lane and
 * asynchronous reads for the recovery and old-mapping lookups.
 */
module mapTableRam (
    input  logic                                                clk,
    input  logic [renamePkg::COMMIT_WIDTH-1:0]                  we,
    input  renamePkg::logRegNum_t [renamePkg::COMMIT_WIDTH-1:0] wa,
    input  renamePkg::phyRegNum_t [renamePkg::COMMIT_WIDTH-1:0] wv,
    input  renamePkg::logRegNum_t [renamePkg::MAP_READ_NUM-1:0] ra,
    output renamePkg::phyRegNum_t [renamePkg::MAP_READ_NUM-1:0] rv
);
    import renamePkg::*;

    phyRegNum_t mem [LOG_REG_NUM];

    // Ports applied in order
    always_ff @(posedge clk) begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (we[i]) begin
                mem[wa[i]] <= wv[i];
            end
        end
    end

    always_comb begin
        for (int k = 0; k < MAP_READ_NUM; k++) begin
            rv[k] = mem[ra[k]];
        end
    end

    // Same-entry writes must be resolved by the caller
    for (genvar i = 0; i < COMMIT_WIDTH; i++) begin : genWriteCheck
        for (genvar j = i + 1; j < COMMIT_WIDTH; j++) begin : genPair
            writeConflict: assert property (@(posedge clk)
                !(we[i] && we[j] && wa[i] == wa[j]))
                else $error("mapTableRam: ports %0d and %0d write one entry", i, j);
        end
    end

endmodule : mapTableRam

//--- verilog/renamePkg.sv
/*
 * Rename package for the retirement side of the register renamer.
 * Holds the rename widths, register number types, the commit lane
 * struct and the post-reset init state encoding.
 */
package renamePkg;

    // Lane and port counts
    localparam int COMMIT_WIDTH = 2;
    localparam int READ_WIDTH = 2;

    // Register file sizes
    localparam int LOG_REG_NUM = 32;
    localparam int PHY_REG_NUM = 64;

    // Registers left over after the initial identity-plus-offset mapping
    localparam int FREE_LIST_ENTRY_NUM = PHY_REG_NUM - LOG_REG_NUM;

    // Recovery ports first, then one lookup per commit lane
    localparam int MAP_READ_NUM = READ_WIDTH + COMMIT_WIDTH;

    localparam int LOG_REG_WIDTH = $clog2(LOG_REG_NUM);
    localparam int PHY_REG_WIDTH = $clog2(PHY_REG_NUM);
    localparam int SWEEP_IDX_WIDTH = $clog2(LOG_REG_NUM);

    typedef logic [LOG_REG_WIDTH-1:0] logRegNum_t;
    typedef logic [PHY_REG_WIDTH-1:0] phyRegNum_t;
    typedef logic [SWEEP_IDX_WIDTH-1:0] sweepIdx_t;

    // One retiring instruction
    typedef struct packed {
        logic valid;
        logRegNum_t logReg;
        phyRegNum_t phyReg;
    } commitLane_t;

    // Post-reset fill sequence
    typedef enum logic [1:0] {
        INIT_START,
        INIT_SWEEP,
        READY
    } initState_t;

endpackage : renamePkg
